//--- common/ib_config.svh
`ifndef IB_CONFIG_SVH
`define IB_CONFIG_SVH

// buffer entries, also the fetch group width
`define IB_DEPTH 4
`define ROB_DEPTH 16

`define DATA_W 16
`define REG_W 4
`define OP_W 4
`define IMM_W 8

`endif

//--- common/ib_pkg.sv
`include "ib_config.svh"

package ib_pkg;

    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`REG_W-1:0] reg_idx_t;
    // wraps modulo ROB_DEPTH
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [`OP_W-1:0] opcode_t;
    typedef logic [`IMM_W-1:0] imm_t;

    // age position, 0 is oldest
    typedef logic [$clog2(`IB_DEPTH)-1:0] slot_t;
    // entry count, one wider than a slot
    typedef logic [$clog2(`IB_DEPTH):0] count_t;

    // value 3 reserved
    typedef enum logic [1:0] {
        UNIT_FXU    = 2'd0,
        UNIT_BRANCH = 2'd1,
        UNIT_HALT   = 2'd2
    } unit_t;

    function automatic logic is_mov_imm(opcode_t op);
        return op == opcode_t'(5) || op == opcode_t'(6);
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return op == opcode_t'(0) || op == opcode_t'(1) || op == opcode_t'(2) ||
               op == opcode_t'(4) || is_mov_imm(op);
    endfunction

endpackage

//--- buffer/ib_entry_store.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module ib_entry_store import ib_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     if_valid,
    input  opcode_t  [`IB_DEPTH-1:0] opcode,
    input  imm_t     [`IB_DEPTH-1:0] imm,
    input  reg_idx_t [`IB_DEPTH-1:0] rt,
    input  unit_t    [`IB_DEPTH-1:0] unit,
    input  logic     [`IB_DEPTH-1:0] uses_rb,
    input  logic     [`IB_DEPTH-1:0] a_local,
    input  rob_tag_t [`IB_DEPTH-1:0] a_local_owner,
    input  logic     [`IB_DEPTH-1:0] b_local,
    input  rob_tag_t [`IB_DEPTH-1:0] b_local_owner,
    input  data_t    [`IB_DEPTH-1:0] ra_value,
    input  logic     [`IB_DEPTH-1:0] ra_busy,
    input  rob_tag_t [`IB_DEPTH-1:0] ra_owner,
    input  data_t    [`IB_DEPTH-1:0] rb_value,
    input  logic     [`IB_DEPTH-1:0] rb_busy,
    input  rob_tag_t [`IB_DEPTH-1:0] rb_owner,
    input  count_t                   issue_count,
    output count_t                   num_fetch,
    output logic     [`IB_DEPTH-1:0] ent_valid,
    output opcode_t  [`IB_DEPTH-1:0] ent_opcode,
    output imm_t     [`IB_DEPTH-1:0] ent_imm,
    output reg_idx_t [`IB_DEPTH-1:0] ent_rt,
    output unit_t    [`IB_DEPTH-1:0] ent_unit,
    output logic     [`IB_DEPTH-1:0] ent_uses_rb,
    output logic     [`IB_DEPTH-1:0] ent_a_track,
    output rob_tag_t [`IB_DEPTH-1:0] ent_a_owner,
    output data_t    [`IB_DEPTH-1:0] ent_a_value,
    output logic     [`IB_DEPTH-1:0] ent_b_track,
    output rob_tag_t [`IB_DEPTH-1:0] ent_b_owner,
    output data_t    [`IB_DEPTH-1:0] ent_b_value
);

    // circular store, indexed physically
    opcode_t  st_opcode  [`IB_DEPTH];
    imm_t     st_imm     [`IB_DEPTH];
    reg_idx_t st_rt      [`IB_DEPTH];
    unit_t    st_unit    [`IB_DEPTH];
    logic     st_uses_rb [`IB_DEPTH];
    logic     st_a_track [`IB_DEPTH];
    rob_tag_t st_a_owner [`IB_DEPTH];
    data_t    st_a_value [`IB_DEPTH];
    logic     st_b_track [`IB_DEPTH];
    rob_tag_t st_b_owner [`IB_DEPTH];
    data_t    st_b_value [`IB_DEPTH];

    slot_t  head;
    count_t count;

    // freed slots plus the ones leaving this cycle
    assign num_fetch = count_t'(`IB_DEPTH) - count + issue_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            count <= '0;
        end else begin
            head <= head + slot_t'(issue_count);
            // a fetch always tops the buffer up to full
            count <= if_valid ? count_t'(`IB_DEPTH) : count - issue_count;
        end
    end

    // append behind the current tail, which also covers issued slots
    always_ff @(posedge clk) begin
        slot_t wa;
        for (int i = 0; i < `IB_DEPTH; i++) begin
            wa = head + slot_t'(count) + slot_t'(i);
            if (if_valid && i < int'(num_fetch)) begin
                st_opcode[wa]  <= opcode[i];
                st_imm[wa]     <= imm[i];
                st_rt[wa]      <= rt[i];
                st_unit[wa]    <= unit[i];
                st_uses_rb[wa] <= uses_rb[i];
                st_a_track[wa] <= a_local[i] | ra_busy[i];
                st_a_owner[wa] <= a_local[i] ? a_local_owner[i] : ra_owner[i];
                st_a_value[wa] <= ra_value[i];
                st_b_track[wa] <= b_local[i] | rb_busy[i];
                st_b_owner[wa] <= b_local[i] ? b_local_owner[i] : rb_owner[i];
                st_b_value[wa] <= rb_value[i];
            end
        end
    end

    for (genvar i = 0; i < `IB_DEPTH; i++) begin : g_view
        slot_t rd;
        assign rd = head + slot_t'(i);

        assign ent_valid[i]   = count > count_t'(i);
        assign ent_opcode[i]  = st_opcode[rd];
        assign ent_imm[i]     = st_imm[rd];
        assign ent_rt[i]      = st_rt[rd];
        assign ent_unit[i]    = st_unit[rd];
        assign ent_uses_rb[i] = st_uses_rb[rd];
        assign ent_a_track[i] = st_a_track[rd];
        assign ent_a_owner[i] = st_a_owner[rd];
        assign ent_a_value[i] = st_a_value[rd];
        assign ent_b_track[i] = st_b_track[rd];
        assign ent_b_owner[i] = st_b_owner[rd];
        assign ent_b_value[i] = st_b_value[rd];
    end

endmodule

//--- buffer/operand_resolve.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module operand_resolve import ib_pkg::*; (
    input  opcode_t  [`IB_DEPTH-1:0]  ent_opcode,
    input  logic     [`IB_DEPTH-1:0]  ent_uses_rb,
    input  logic     [`IB_DEPTH-1:0]  ent_a_track,
    input  rob_tag_t [`IB_DEPTH-1:0]  ent_a_owner,
    input  data_t    [`IB_DEPTH-1:0]  ent_a_value,
    input  logic     [`IB_DEPTH-1:0]  ent_b_track,
    input  rob_tag_t [`IB_DEPTH-1:0]  ent_b_owner,
    input  data_t    [`IB_DEPTH-1:0]  ent_b_value,
    input  logic     [`ROB_DEPTH-1:0] rob_done,
    input  data_t    [`ROB_DEPTH-1:0] rob_value,
    output logic     [`IB_DEPTH-1:0]  a_ready,
    output data_t    [`IB_DEPTH-1:0]  a_value,
    output logic     [`IB_DEPTH-1:0]  b_ready,
    output data_t    [`IB_DEPTH-1:0]  b_value
);

    for (genvar i = 0; i < `IB_DEPTH; i++) begin : g_opnd
        logic mov_imm;
        assign mov_imm = is_mov_imm(ent_opcode[i]);

        // local deps and busy registers both wait on their owner
        assign a_ready[i] = !ent_a_track[i] || rob_done[ent_a_owner[i]] || mov_imm;
        assign b_ready[i] = !ent_b_track[i] || rob_done[ent_b_owner[i]] || mov_imm ||
                            !ent_uses_rb[i];

        assign a_value[i] = ent_a_track[i] ? rob_value[ent_a_owner[i]] : ent_a_value[i];
        assign b_value[i] = ent_b_track[i] ? rob_value[ent_b_owner[i]] : ent_b_value[i];
    end

endmodule

//--- issue/issue_select.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module issue_select import ib_pkg::*; (
    input  logic     [`IB_DEPTH-1:0] ent_valid,
    input  unit_t    [`IB_DEPTH-1:0] ent_unit,
    input  opcode_t  [`IB_DEPTH-1:0] ent_opcode,
    input  imm_t     [`IB_DEPTH-1:0] ent_imm,
    input  rob_tag_t [`IB_DEPTH-1:0] ent_a_owner,
    input  rob_tag_t [`IB_DEPTH-1:0] ent_b_owner,
    input  logic     [`IB_DEPTH-1:0] a_ready,
    input  data_t    [`IB_DEPTH-1:0] a_value,
    input  logic     [`IB_DEPTH-1:0] b_ready,
    input  data_t    [`IB_DEPTH-1:0] b_value,
    input  rob_tag_t                 rob_head_idx,
    input  logic                     fxu_0_full,
    input  logic                     fxu_1_full,
    input  logic                     branch_full,
    output logic                     fxu0_valid,
    output rob_tag_t                 fxu0_rob_idx,
    output opcode_t                  fxu0_opcode,
    output imm_t                     fxu0_imm,
    output logic                     fxu0_a_ready,
    output data_t                    fxu0_a_value,
    output rob_tag_t                 fxu0_a_owner,
    output logic                     fxu0_b_ready,
    output data_t                    fxu0_b_value,
    output rob_tag_t                 fxu0_b_owner,
    output logic                     fxu1_valid,
    output rob_tag_t                 fxu1_rob_idx,
    output opcode_t                  fxu1_opcode,
    output imm_t                     fxu1_imm,
    output logic                     fxu1_a_ready,
    output data_t                    fxu1_a_value,
    output rob_tag_t                 fxu1_a_owner,
    output logic                     fxu1_b_ready,
    output data_t                    fxu1_b_value,
    output rob_tag_t                 fxu1_b_owner,
    output logic                     br_valid,
    output rob_tag_t                 br_rob_idx,
    output opcode_t                  br_opcode,
    output logic                     br_a_ready,
    output data_t                    br_a_value,
    output rob_tag_t                 br_a_owner,
    output logic                     br_b_ready,
    output data_t                    br_b_value,
    output rob_tag_t                 br_b_owner,
    output logic     [`IB_DEPTH-1:0] issued,
    output count_t                   issue_count
);

    slot_t sel0;
    slot_t sel1;
    slot_t selb;

    // oldest first, first entry without a port blocks the rest
    always_comb begin
        logic blocked;
        blocked     = 1'b0;
        fxu0_valid  = 1'b0;
        fxu1_valid  = 1'b0;
        br_valid    = 1'b0;
        sel0        = '0;
        sel1        = '0;
        selb        = '0;
        issued      = '0;
        issue_count = '0;
        for (int i = 0; i < `IB_DEPTH; i++) begin
            if (ent_valid[i] && !blocked) begin
                case (ent_unit[i])
                    UNIT_FXU: begin
                        if (!fxu_0_full && !fxu0_valid) begin
                            fxu0_valid = 1'b1;
                            sel0       = slot_t'(i);
                        end else if (!fxu_1_full && !fxu1_valid) begin
                            fxu1_valid = 1'b1;
                            sel1       = slot_t'(i);
                        end else begin
                            blocked = 1'b1;
                        end
                    end
                    UNIT_BRANCH: begin
                        if (!branch_full && !br_valid) begin
                            br_valid = 1'b1;
                            selb     = slot_t'(i);
                        end else begin
                            blocked = 1'b1;
                        end
                    end
                    // halt needs no unit
                    default: ;
                endcase
                if (!blocked) begin
                    issued[i]   = 1'b1;
                    issue_count = issue_count + 1'b1;
                end
            end
        end
    end

    assign fxu0_rob_idx = rob_head_idx + rob_tag_t'(sel0);
    assign fxu0_opcode  = ent_opcode[sel0];
    assign fxu0_imm     = ent_imm[sel0];
    assign fxu0_a_ready = a_ready[sel0];
    assign fxu0_a_value = a_value[sel0];
    assign fxu0_a_owner = ent_a_owner[sel0];
    assign fxu0_b_ready = b_ready[sel0];
    assign fxu0_b_value = b_value[sel0];
    assign fxu0_b_owner = ent_b_owner[sel0];

    assign fxu1_rob_idx = rob_head_idx + rob_tag_t'(sel1);
    assign fxu1_opcode  = ent_opcode[sel1];
    assign fxu1_imm     = ent_imm[sel1];
    assign fxu1_a_ready = a_ready[sel1];
    assign fxu1_a_value = a_value[sel1];
    assign fxu1_a_owner = ent_a_owner[sel1];
    assign fxu1_b_ready = b_ready[sel1];
    assign fxu1_b_value = b_value[sel1];
    assign fxu1_b_owner = ent_b_owner[sel1];

    // branch port carries no immediate
    assign br_rob_idx = rob_head_idx + rob_tag_t'(selb);
    assign br_opcode  = ent_opcode[selb];
    assign br_a_ready = a_ready[selb];
    assign br_a_value = a_value[selb];
    assign br_a_owner = ent_a_owner[selb];
    assign br_b_ready = b_ready[selb];
    assign br_b_value = b_value[selb];
    assign br_b_owner = ent_b_owner[selb];

endmodule

//--- issue/rob_rename_alloc.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module rob_rename_alloc import ib_pkg::*; (
    input  logic     [`IB_DEPTH-1:0] issued,
    input  reg_idx_t [`IB_DEPTH-1:0] ent_rt,
    input  opcode_t  [`IB_DEPTH-1:0] ent_opcode,
    input  unit_t    [`IB_DEPTH-1:0] ent_unit,
    input  rob_tag_t                 rob_head_idx,
    output logic     [`IB_DEPTH-1:0] rob_alloc_valid,
    output reg_idx_t [`IB_DEPTH-1:0] rob_alloc_rt,
    output logic     [`IB_DEPTH-1:0] rob_alloc_halt,
    output logic     [`IB_DEPTH-1:0] rt_update_en,
    output reg_idx_t [`IB_DEPTH-1:0] rt_update_reg,
    output rob_tag_t [`IB_DEPTH-1:0] rt_update_owner
);

    logic [`IB_DEPTH-1:0] writer;

    assign rob_alloc_valid = issued;
    assign rob_alloc_rt    = ent_rt;
    assign rt_update_reg   = ent_rt;

    for (genvar i = 0; i < `IB_DEPTH; i++) begin : g_alloc
        assign writer[i]          = issued[i] && writes_reg(ent_opcode[i]);
        assign rob_alloc_halt[i]  = issued[i] && ent_unit[i] == UNIT_HALT;
        assign rt_update_owner[i] = rob_head_idx + rob_tag_t'(i);
    end

    // youngest issued writer of a register wins
    always_comb begin
        logic shadowed;
        for (int i = 0; i < `IB_DEPTH; i++) begin
            shadowed = 1'b0;
            for (int j = i + 1; j < `IB_DEPTH; j++) begin
                if (writer[j] && ent_rt[j] == ent_rt[i]) begin
                    shadowed = 1'b1;
                end
            end
            rt_update_en[i] = writer[i] && !shadowed;
        end
    end

endmodule

//--- src/instruction_buffer.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module instruction_buffer import ib_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    // fetch group
    input  logic                          if_valid,
    input  opcode_t  [`IB_DEPTH-1:0]      opcode,
    input  imm_t     [`IB_DEPTH-1:0]      imm,
    input  reg_idx_t [`IB_DEPTH-1:0]      rt,
    input  unit_t    [`IB_DEPTH-1:0]      unit,
    input  logic     [`IB_DEPTH-1:0]      uses_rb,
    input  logic     [`IB_DEPTH-1:0]      a_local,
    input  rob_tag_t [`IB_DEPTH-1:0]      a_local_owner,
    input  logic     [`IB_DEPTH-1:0]      b_local,
    input  rob_tag_t [`IB_DEPTH-1:0]      b_local_owner,
    // register file
    input  data_t    [`IB_DEPTH-1:0]      ra_value,
    input  logic     [`IB_DEPTH-1:0]      ra_busy,
    input  rob_tag_t [`IB_DEPTH-1:0]      ra_owner,
    input  data_t    [`IB_DEPTH-1:0]      rb_value,
    input  logic     [`IB_DEPTH-1:0]      rb_busy,
    input  rob_tag_t [`IB_DEPTH-1:0]      rb_owner,
    // rob status
    input  rob_tag_t                      rob_head_idx,
    input  logic     [`ROB_DEPTH-1:0]     rob_done,
    input  data_t    [`ROB_DEPTH-1:0]     rob_value,
    input  logic                          fxu_0_full,
    input  logic                          fxu_1_full,
    input  logic                          branch_full,
    output count_t                        num_fetch,
    output logic                          fxu0_valid,
    output rob_tag_t                      fxu0_rob_idx,
    output opcode_t                       fxu0_opcode,
    output imm_t                          fxu0_imm,
    output logic                          fxu0_a_ready,
    output data_t                         fxu0_a_value,
    output rob_tag_t                      fxu0_a_owner,
    output logic                          fxu0_b_ready,
    output data_t                         fxu0_b_value,
    output rob_tag_t                      fxu0_b_owner,
    output logic                          fxu1_valid,
    output rob_tag_t                      fxu1_rob_idx,
    output opcode_t                       fxu1_opcode,
    output imm_t                          fxu1_imm,
    output logic                          fxu1_a_ready,
    output data_t                         fxu1_a_value,
    output rob_tag_t                      fxu1_a_owner,
    output logic                          fxu1_b_ready,
    output data_t                         fxu1_b_value,
    output rob_tag_t                      fxu1_b_owner,
    output logic                          br_valid,
    output rob_tag_t                      br_rob_idx,
    output opcode_t                       br_opcode,
    output logic                          br_a_ready,
    output data_t                         br_a_value,
    output rob_tag_t                      br_a_owner,
    output logic                          br_b_ready,
    output data_t                         br_b_value,
    output rob_tag_t                      br_b_owner,
    output logic     [`IB_DEPTH-1:0]      rob_alloc_valid,
    output reg_idx_t [`IB_DEPTH-1:0]      rob_alloc_rt,
    output logic     [`IB_DEPTH-1:0]      rob_alloc_halt,
    output logic     [`IB_DEPTH-1:0]      rt_update_en,
    output reg_idx_t [`IB_DEPTH-1:0]      rt_update_reg,
    output rob_tag_t [`IB_DEPTH-1:0]      rt_update_owner
);

    // age-ordered entry views
    logic     [`IB_DEPTH-1:0] ent_valid;
    opcode_t  [`IB_DEPTH-1:0] ent_opcode;
    imm_t     [`IB_DEPTH-1:0] ent_imm;
    reg_idx_t [`IB_DEPTH-1:0] ent_rt;
    unit_t    [`IB_DEPTH-1:0] ent_unit;
    logic     [`IB_DEPTH-1:0] ent_uses_rb;
    logic     [`IB_DEPTH-1:0] ent_a_track;
    rob_tag_t [`IB_DEPTH-1:0] ent_a_owner;
    data_t    [`IB_DEPTH-1:0] ent_a_value;
    logic     [`IB_DEPTH-1:0] ent_b_track;
    rob_tag_t [`IB_DEPTH-1:0] ent_b_owner;
    data_t    [`IB_DEPTH-1:0] ent_b_value;

    // resolved operands
    logic     [`IB_DEPTH-1:0] a_ready;
    data_t    [`IB_DEPTH-1:0] a_value;
    logic     [`IB_DEPTH-1:0] b_ready;
    data_t    [`IB_DEPTH-1:0] b_value;

    logic     [`IB_DEPTH-1:0] issued;
    count_t                   issue_count;

    ib_entry_store ib_entry_store_i (.*);

    operand_resolve operand_resolve_i (.*);

    issue_select issue_select_i (.*);

    rob_rename_alloc rob_rename_alloc_i (.*);

endmodule

//--- bench/ib_sva.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module ib_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 fxu_0_full,
    input logic                 fxu_1_full,
    input logic                 branch_full,
    input logic                 fxu0_valid,
    input logic                 fxu1_valid,
    input logic                 br_valid,
    input logic [`IB_DEPTH-1:0] rob_alloc_valid,
    input logic [`IB_DEPTH-1:0] rt_update_en
);

    // a full unit gets no dispatch
    fxu0_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        fxu0_valid |-> !fxu_0_full) else $error("fxu0 dispatch while full");
    fxu1_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        fxu1_valid |-> !fxu_1_full) else $error("fxu1 dispatch while full");
    br_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        br_valid |-> !branch_full) else $error("branch dispatch while full");

    // allocation is oldest first, no gaps
    alloc_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        ((rob_alloc_valid + 1'b1) & rob_alloc_valid) == '0)
        else $error("rob_alloc_valid is not a run of ones from position 0");

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |->
        !fxu0_valid && !fxu1_valid && !br_valid && rob_alloc_valid == '0 && rt_update_en == '0)
        else $error("outputs valid in the first cycle after reset");

endmodule

bind instruction_buffer ib_sva ib_sva_i (.*);

//--- bench/ib_tb.sv
`timescale 1ns/1ps
`include "ib_config.svh"

module ib_tb import ib_pkg::*; ();

    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT    = NUM_CYCLES + NUM_CYCLES / 10;
    localparam int PROG_LEN   = 4 * NUM_CYCLES + 8;

    logic clk, rst_n, if_valid, fxu_0_full, fxu_1_full, branch_full;
    opcode_t  [`IB_DEPTH-1:0]  opcode;
    imm_t     [`IB_DEPTH-1:0]  imm;
    reg_idx_t [`IB_DEPTH-1:0]  rt;
    unit_t    [`IB_DEPTH-1:0]  unit;
    logic     [`IB_DEPTH-1:0]  uses_rb, a_local, b_local, ra_busy, rb_busy;
    rob_tag_t [`IB_DEPTH-1:0]  a_local_owner, b_local_owner, ra_owner, rb_owner;
    data_t    [`IB_DEPTH-1:0]  ra_value, rb_value;
    rob_tag_t                  rob_head_idx;
    logic     [`ROB_DEPTH-1:0] rob_done;
    data_t    [`ROB_DEPTH-1:0] rob_value;
    count_t                    num_fetch;
    logic fxu0_valid, fxu0_a_ready, fxu0_b_ready, fxu1_valid, fxu1_a_ready, fxu1_b_ready;
    logic br_valid, br_a_ready, br_b_ready;
    rob_tag_t fxu0_rob_idx, fxu0_a_owner, fxu0_b_owner, fxu1_rob_idx, fxu1_a_owner;
    rob_tag_t fxu1_b_owner, br_rob_idx, br_a_owner, br_b_owner;
    opcode_t  fxu0_opcode, fxu1_opcode, br_opcode;
    imm_t     fxu0_imm, fxu1_imm;
    data_t    fxu0_a_value, fxu0_b_value, fxu1_a_value, fxu1_b_value, br_a_value, br_b_value;
    logic     [`IB_DEPTH-1:0] rob_alloc_valid, rob_alloc_halt, rt_update_en;
    reg_idx_t [`IB_DEPTH-1:0] rob_alloc_rt, rt_update_reg;
    rob_tag_t [`IB_DEPTH-1:0] rt_update_owner;

    // program in fetch order
    opcode_t  prog_op   [PROG_LEN];
    imm_t     prog_imm  [PROG_LEN];
    reg_idx_t prog_rt   [PROG_LEN];
    unit_t    prog_unit [PROG_LEN];
    logic     prog_urb  [PROG_LEN];

    // reference buffer with index 0 oldest
    opcode_t  m_op[`IB_DEPTH];
    imm_t     m_imm[`IB_DEPTH];
    reg_idx_t m_rt[`IB_DEPTH];
    unit_t    m_unit[`IB_DEPTH];
    logic     m_urb[`IB_DEPTH], m_at[`IB_DEPTH], m_bt[`IB_DEPTH];
    rob_tag_t m_ao[`IB_DEPTH], m_bo[`IB_DEPTH];
    data_t    m_av[`IB_DEPTH], m_bv[`IB_DEPTH];
    logic     exp_ar[`IB_DEPTH], exp_br[`IB_DEPTH];
    data_t    exp_av[`IB_DEPTH], exp_bv[`IB_DEPTH];

    logic [31:0] rng;
    rob_tag_t    head_next;
    int          m_count, pc, alloc_ptr, cyc, errors, checks;

    instruction_buffer instruction_buffer_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic record_check(input string name, input logic bad,
                                input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (bad) begin
            errors++;
            $display("** Error %s at cycle %0d: expected %0h, actual %0h",
                     name, cyc, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_tag(input string name, input rob_tag_t expected, input rob_tag_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_opcode(input string name, input opcode_t expected, input opcode_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_imm(input string name, input imm_t expected, input imm_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        record_check(name, expected !== actual, 32'(expected), 32'(actual));
    endtask

    task automatic build_program();
        logic [31:0] r;
        for (int k = 0; k < PROG_LEN; k++) begin
            r = next_rand();
            prog_op[k]   = opcode_t'(r);
            prog_imm[k]  = imm_t'(r >> 4);
            prog_rt[k]   = reg_idx_t'(r >> 12);
            prog_urb[k]  = r[16];
            // mostly fixed-point work
            prog_unit[k] = r[19:17] < 3'd5 ? UNIT_FXU : (r[19:17] < 3'd7 ? UNIT_BRANCH : UNIT_HALT);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        if_valid     = r[1:0] != 2'd0;
        fxu_0_full   = r[3:2] == 2'd0;
        fxu_1_full   = r[5:4] == 2'd0;
        branch_full  = r[7:6] == 2'd0;
        r            = next_rand();
        rob_done     = r[`ROB_DEPTH-1:0];
        rob_head_idx = head_next;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_value[i] = data_t'(next_rand());
        end
        for (int i = 0; i < `IB_DEPTH; i++) begin
            r = next_rand();
            opcode[i]        = prog_op[pc + i];
            imm[i]           = prog_imm[pc + i];
            rt[i]            = prog_rt[pc + i];
            unit[i]          = prog_unit[pc + i];
            uses_rb[i]       = prog_urb[pc + i];
            a_local[i]       = r[0] & r[1];
            b_local[i]       = r[2] & r[3];
            ra_busy[i]       = r[4];
            rb_busy[i]       = r[5];
            a_local_owner[i] = rob_tag_t'(r >> 8);
            b_local_owner[i] = rob_tag_t'(r >> 12);
            ra_owner[i]      = rob_tag_t'(r >> 16);
            rb_owner[i]      = rob_tag_t'(r >> 20);
            ra_value[i]      = data_t'(next_rand());
            rb_value[i]      = data_t'(next_rand());
        end
    endtask

    task automatic check_port(input string port, input int pos, input logic has_imm,
                              input logic valid, input rob_tag_t idx, input opcode_t op,
                              input imm_t im, input logic ar, input data_t av, input rob_tag_t ao,
                              input logic br, input data_t bv, input rob_tag_t bo);
        check_bit({port, "_valid"}, pos >= 0, valid);
        if (pos >= 0 && valid) begin
            check_tag({port, "_rob_idx"}, rob_head_idx + rob_tag_t'(pos), idx);
            check_opcode({port, "_opcode"}, m_op[pos], op);
            if (has_imm) begin
                check_imm({port, "_imm"}, m_imm[pos], im);
            end
            check_bit({port, "_a_ready"}, exp_ar[pos], ar);
            check_data({port, "_a_value"}, exp_av[pos], av);
            check_tag({port, "_a_owner"}, m_ao[pos], ao);
            check_bit({port, "_b_ready"}, exp_br[pos], br);
            check_data({port, "_b_value"}, exp_bv[pos], bv);
            check_tag({port, "_b_owner"}, m_bo[pos], bo);
        end
    endtask

    // compare this cycle and step the model across the coming edge
    task automatic check_cycle();
        logic blocked;
        logic wr;
        logic [`IB_DEPTH-1:0] iss;
        int sel0, sel1, selb, n_iss, nf, p;
        blocked = 1'b0;
        iss     = '0;
        n_iss   = 0;
        sel0    = -1;
        sel1    = -1;
        selb    = -1;
        for (int i = 0; i < m_count; i++) begin
            exp_ar[i] = !m_at[i] || rob_done[m_ao[i]] || (m_op[i] inside {4'd5, 4'd6});
            exp_br[i] = !m_bt[i] || rob_done[m_bo[i]] || (m_op[i] inside {4'd5, 4'd6}) ||
                        !m_urb[i];
            exp_av[i] = m_at[i] ? rob_value[m_ao[i]] : m_av[i];
            exp_bv[i] = m_bt[i] ? rob_value[m_bo[i]] : m_bv[i];
            if (!blocked) begin
                if (m_unit[i] == UNIT_FXU) begin
                    if (!fxu_0_full && sel0 < 0) sel0 = i;
                    else if (!fxu_1_full && sel1 < 0) sel1 = i;
                    else blocked = 1'b1;
                end else if (m_unit[i] == UNIT_BRANCH) begin
                    if (!branch_full && selb < 0) selb = i;
                    else blocked = 1'b1;
                end
                if (!blocked) begin
                    iss[i] = 1'b1;
                    n_iss++;
                end
            end
        end
        nf = `IB_DEPTH - m_count + n_iss;
        check_count("num_fetch", count_t'(nf), num_fetch);
        check_port("fxu0", sel0, 1'b1, fxu0_valid, fxu0_rob_idx, fxu0_opcode, fxu0_imm,
                   fxu0_a_ready, fxu0_a_value, fxu0_a_owner,
                   fxu0_b_ready, fxu0_b_value, fxu0_b_owner);
        check_port("fxu1", sel1, 1'b1, fxu1_valid, fxu1_rob_idx, fxu1_opcode, fxu1_imm,
                   fxu1_a_ready, fxu1_a_value, fxu1_a_owner,
                   fxu1_b_ready, fxu1_b_value, fxu1_b_owner);
        check_port("br", selb, 1'b0, br_valid, br_rob_idx, br_opcode, '0,
                   br_a_ready, br_a_value, br_a_owner, br_b_ready, br_b_value, br_b_owner);
        for (int i = 0; i < `IB_DEPTH; i++) begin
            check_bit($sformatf("rob_alloc_valid[%0d]", i), iss[i], rob_alloc_valid[i]);
            check_bit($sformatf("rob_alloc_halt[%0d]", i), iss[i] && m_unit[i] == UNIT_HALT,
                      rob_alloc_halt[i]);
            // allocated targets must replay the program exactly once
            if (rob_alloc_valid[i]) begin
                check_reg("rob_alloc_rt", prog_rt[alloc_ptr], rob_alloc_rt[i]);
                alloc_ptr++;
            end
            wr = iss[i] && (m_op[i] inside {4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6});
            for (int j = i + 1; j < `IB_DEPTH; j++) begin
                if (iss[j] && (m_op[j] inside {4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6}) &&
                    m_rt[j] == m_rt[i]) wr = 1'b0;
            end
            check_bit($sformatf("rt_update_en[%0d]", i), wr, rt_update_en[i]);
            if (wr) begin
                check_reg("rt_update_reg", m_rt[i], rt_update_reg[i]);
                check_tag("rt_update_owner", rob_head_idx + rob_tag_t'(i), rt_update_owner[i]);
            end
        end
        for (int j = 0; j + n_iss < m_count; j++) begin
            m_op[j]   = m_op[j + n_iss];
            m_imm[j]  = m_imm[j + n_iss];
            m_rt[j]   = m_rt[j + n_iss];
            m_unit[j] = m_unit[j + n_iss];
            m_urb[j]  = m_urb[j + n_iss];
            m_at[j]   = m_at[j + n_iss];
            m_ao[j]   = m_ao[j + n_iss];
            m_av[j]   = m_av[j + n_iss];
            m_bt[j]   = m_bt[j + n_iss];
            m_bo[j]   = m_bo[j + n_iss];
            m_bv[j]   = m_bv[j + n_iss];
        end
        m_count   = m_count - n_iss;
        head_next = rob_head_idx + rob_tag_t'(n_iss);
        if (if_valid) begin
            for (int k = 0; k < nf; k++) begin
                p         = m_count + k;
                m_op[p]   = opcode[k];
                m_imm[p]  = imm[k];
                m_rt[p]   = rt[k];
                m_unit[p] = unit[k];
                m_urb[p]  = uses_rb[k];
                m_at[p]   = a_local[k] || ra_busy[k];
                m_ao[p]   = a_local[k] ? a_local_owner[k] : ra_owner[k];
                m_av[p]   = ra_value[k];
                m_bt[p]   = b_local[k] || rb_busy[k];
                m_bo[p]   = b_local[k] ? b_local_owner[k] : rb_owner[k];
                m_bv[p]   = rb_value[k];
            end
            m_count = m_count + nf;
            pc      = pc + nf;
        end
    endtask

    initial begin
        int ticks;
        ticks = 0;
        while (ticks < TIMEOUT) begin
            @(posedge clk);
            ticks++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rng       = 32'd79403;
        m_count   = 0;
        pc        = 0;
        alloc_ptr = 0;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        head_next = '0;
        build_program();
        drive_inputs();
        if_valid = 1'b0;
        rst_n    = 1'b0;
        repeat (16) @(posedge clk);
        #5 rst_n = 1'b1;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            #5 drive_inputs();
            #40 check_cycle();
        end
        $display("summary: %0d checks, %0d errors, %0d instructions allocated",
                 checks, errors, alloc_ptr);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
common/ib_pkg.sv
buffer/ib_entry_store.sv
buffer/operand_resolve.sv
issue/issue_select.sv
issue/rob_rename_alloc.sv
src/instruction_buffer.sv
bench/ib_sva.sv
bench/ib_tb.sv

//--- Makefile
obj_dir/Vib_tb: sources.f $(wildcard common/* src/*.sv buffer/*.sv issue/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module ib_tb -f sources.f

run: obj_dir/Vib_tb
	@out="$$(./obj_dir/Vib_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: run clean
